// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -j 0
TOP       ?= apb_xbar_tb
RTL_TOP   ?= apb_xbar
FILELIST  ?= apb_xbar.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: apb_xbar.f
common/apb_xbar_pkg.sv
source/apb_cmd_capture.sv
source/apb_rr_arbiter.sv
source/apb_target_port.sv
source/apb_xbar.sv
bench/apb_slave_model.sv
bench/apb_xbar_tb.sv

// File: bench/apb_slave_model.sv
`timescale 1ns/10ps
`default_nettype none

module apb_slave_model #(
    parameter int slave_id = 0
) (
    input  logic                                aclk,
    input  logic                                aresetn,
    input  logic                                i_psel,
    input  logic                                i_penable,
    input  logic                                i_pwrite,
    input  logic [apb_xbar_pkg::addr_width-1:0] i_paddr,
    input  logic [apb_xbar_pkg::data_width-1:0] i_pwdata,
    input  logic [apb_xbar_pkg::strb_width-1:0] i_pstrb,
    output logic                                o_pready,
    output logic [apb_xbar_pkg::data_width-1:0] o_prdata,
    output logic                                o_pslverr
);

    import apb_xbar_pkg::*;

    logic [data_width-1:0] mem [1024];
    logic [1:0]            wait_cnt;
    logic [9:0]            word;
    logic                  bad;

    assign word = i_paddr[offset_width-1:2];
    assign bad  = i_paddr[offset_width-1];     // error window, never written

    // fill word carries slave, word index and byte offset
    initial begin
        for (int w = 0; w < 1024; w++) begin
            mem[w] <= {16'hc0de, 4'(slave_id), 10'(w), 2'b00};
        end
    end

    always @(posedge aclk or negedge aresetn) begin
        logic [1:0] waits;
        if (!aresetn) begin
            o_pready  <= 1'b0;
            o_prdata  <= '0;
            o_pslverr <= 1'b0;
            wait_cnt  <= 2'd0;
        end else if (i_psel && !i_penable) begin
            waits     = 2'($urandom % 4);          // zero to three wait states
            wait_cnt  <= waits;
            o_pready  <= (waits == 2'd0);
            o_prdata  <= bad ? '0 : mem[word];
            o_pslverr <= bad;
        end else if (i_psel && i_penable && !o_pready) begin
            wait_cnt <= wait_cnt - 2'd1;
            o_pready <= (wait_cnt == 2'd1);
        end else begin
            o_pready <= 1'b0;
        end
    end

    always @(posedge aclk) begin
        if (i_psel && i_penable && o_pready && i_pwrite && !bad) begin
            for (int b = 0; b < strb_width; b++) begin
                if (i_pstrb[b]) begin
                    mem[word][8*b +: 8] <= i_pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/apb_xbar_tb.sv
`timescale 1ns/10ps
`default_nettype none

module apb_xbar_tb;

    import apb_xbar_pkg::*;

    localparam int clk_period     = 10;
    localparam int reset_cycles   = 4;
    localparam int burst_len      = 16;
    localparam int num_transfers  = 74;     // all tests together
    localparam int transfer_bound = 20;     // cycles per transfer

    logic aclk;
    logic aresetn;

    logic [num_masters-1:0]                 m_psel;
    logic [num_masters-1:0]                 m_penable;
    logic [num_masters-1:0]                 m_pwrite;
    logic [num_masters-1:0][prot_width-1:0] m_pprot;
    logic [num_masters-1:0][addr_width-1:0] m_paddr;
    logic [num_masters-1:0][data_width-1:0] m_pwdata;
    logic [num_masters-1:0][strb_width-1:0] m_pstrb;
    logic [num_masters-1:0]                 m_pready;
    logic [num_masters-1:0][data_width-1:0] m_prdata;
    logic [num_masters-1:0]                 m_pslverr;

    logic [num_slaves-1:0]                  s_psel;
    logic [num_slaves-1:0]                  s_penable;
    logic [num_slaves-1:0]                  s_pwrite;
    logic [num_slaves-1:0][prot_width-1:0]  s_pprot;
    logic [num_slaves-1:0][addr_width-1:0]  s_paddr;
    logic [num_slaves-1:0][data_width-1:0]  s_pwdata;
    logic [num_slaves-1:0][strb_width-1:0]  s_pstrb;
    logic [num_slaves-1:0]                  s_pready;
    logic [num_slaves-1:0][data_width-1:0]  s_prdata;
    logic [num_slaves-1:0]                  s_pslverr;

    // scoreboard and the expected response of each open transfer
    logic [data_width-1:0]  exp_mem [num_slaves][1024];
    logic [data_width-1:0]  exp_rdata [num_masters];
    logic [num_masters-1:0] exp_slverr;
    logic [num_masters-1:0] exp_check_data;
    logic [num_slaves-1:0]  sel_owned;

    int error_count     = 0;
    int errors_at_start = 0;
    int transfer_count  = 0;
    int test_count      = 0;
    int sel_cycles      = 0;
    int overlap_cycles  = 0;

    apb_xbar u_dut (
        .aclk        (aclk),
        .aresetn     (aresetn),
        .i_m_psel    (m_psel),
        .i_m_penable (m_penable),
        .i_m_pwrite  (m_pwrite),
        .i_m_pprot   (m_pprot),
        .i_m_paddr   (m_paddr),
        .i_m_pwdata  (m_pwdata),
        .i_m_pstrb   (m_pstrb),
        .o_m_pready  (m_pready),
        .o_m_prdata  (m_prdata),
        .o_m_pslverr (m_pslverr),
        .o_s_psel    (s_psel),
        .o_s_penable (s_penable),
        .o_s_pwrite  (s_pwrite),
        .o_s_pprot   (s_pprot),
        .o_s_paddr   (s_paddr),
        .o_s_pwdata  (s_pwdata),
        .o_s_pstrb   (s_pstrb),
        .i_s_pready  (s_pready),
        .i_s_prdata  (s_prdata),
        .i_s_pslverr (s_pslverr)
    );

    for (genvar gs = 0; gs < num_slaves; gs++) begin : gen_slave
        apb_slave_model #(.slave_id(gs)) u_slave (
            .aclk      (aclk),
            .aresetn   (aresetn),
            .i_psel    (s_psel[gs]),
            .i_penable (s_penable[gs]),
            .i_pwrite  (s_pwrite[gs]),
            .i_paddr   (s_paddr[gs]),
            .i_pwdata  (s_pwdata[gs]),
            .i_pstrb   (s_pstrb[gs]),
            .o_pready  (s_pready[gs]),
            .o_prdata  (s_prdata[gs]),
            .o_pslverr (s_pslverr[gs])
        );
    end

    initial begin
        aclk = 1'b0;
        forever #(clk_period / 2) aclk = ~aclk;
    end

    initial begin
        #((num_transfers * transfer_bound + reset_cycles + 20) * clk_period);
        $display("watchdog expired before all tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    always @(posedge aclk) begin
        if (|s_psel) sel_cycles <= sel_cycles + 1;
        if ($countones(s_psel) > 1) overlap_cycles <= overlap_cycles + 1;
    end

    // a selected slave must carry exactly one open master transfer
    always_comb begin
        sel_owned = '0;
        for (int s = 0; s < num_slaves; s++) begin
            for (int m = 0; m < num_masters; m++) begin
                if (m_psel[m] && m_penable[m] && (m_paddr[m] == s_paddr[s])
                    && (m_pwrite[m] == s_pwrite[s])
                    && (m_pprot[m] == s_pprot[s])
                    && (!s_pwrite[s] || (m_pwdata[m] == s_pwdata[s]))
                    && (s_paddr[s][addr_width-1:offset_width] == region_width'(s))) begin
                    sel_owned[s] = 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks

    assert property (@(posedge aclk) (!aresetn || !$past(aresetn))
        |-> ((m_pready == '0) && (s_psel == '0) && (s_penable == '0)))
    else begin
        $display("master pready or slave select active during or right after reset");
        error_count++;
    end

    for (genvar gm = 0; gm < num_masters; gm++) begin : gen_master_check
        assert property (@(posedge aclk) disable iff (!aresetn)
            (m_psel[gm] && m_penable[gm] && m_pready[gm])
            |-> (m_pslverr[gm] == exp_slverr[gm]))
        else begin
            $display("FAILED o_m_pslverr[%0d]: got %h expected %h", gm,
                     $sampled(m_pslverr[gm]), $sampled(exp_slverr[gm]));
            error_count++;
        end

        assert property (@(posedge aclk) disable iff (!aresetn)
            (m_psel[gm] && m_penable[gm] && m_pready[gm] && exp_check_data[gm])
            |-> (m_prdata[gm] == exp_rdata[gm]))
        else begin
            $display("FAILED o_m_prdata[%0d]: got %h expected %h", gm,
                     $sampled(m_prdata[gm]), $sampled(exp_rdata[gm]));
            error_count++;
        end

        // miss answered in the cycle right after the first access cycle
        assert property (@(posedge aclk) disable iff (!aresetn)
            (m_psel[gm] && $rose(m_penable[gm])
             && (m_paddr[gm][addr_width-1:offset_width] >= region_width'(num_slaves)))
            |-> (!m_pready[gm] ##1 (m_pready[gm] && m_pslverr[gm])))
        else begin
            $display("master %0d decode miss was not answered one cycle after access", gm);
            error_count++;
        end
    end

    for (genvar gs = 0; gs < num_slaves; gs++) begin : gen_slave_check
        assert property (@(posedge aclk) disable iff (!aresetn)
            s_psel[gs] |-> sel_owned[gs])
        else begin
            $display("slave %0d selected without a matching master transfer", gs);
            error_count++;
        end

        assert property (@(posedge aclk) disable iff (!aresetn)
            (s_psel[gs] && s_penable[gs] && s_pready[gs]) |=> !s_psel[gs])
        else begin
            $display("slave %0d started a new transfer with no idle cycle", gs);
            error_count++;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus

    function automatic logic [data_width-1:0] fill_word(input int slave, input int word);
        return {16'hc0de, 4'(slave), 10'(word), 2'b00};
    endfunction

    function automatic logic [addr_width-1:0] make_addr(input int region, input int word);
        return {region_width'(region), 10'(word), 2'b00};
    endfunction

    task automatic apb_transfer(input int m, input logic wr,
                                input logic [addr_width-1:0] addr,
                                input logic [data_width-1:0] wdata);
        apb_addr_u a;
        int        slave;
        int        word;
        a.raw = addr;
        slave = int'(a.map.region);
        word  = int'(a.map.offset[offset_width-1:2]);
        if (slave >= num_slaves) begin
            exp_slverr[m]     = 1'b1;
            exp_check_data[m] = 1'b1;
            exp_rdata[m]      = '0;
        end else if (a.map.offset[offset_width-1]) begin
            exp_slverr[m]     = 1'b1;       // slave error window
            exp_check_data[m] = !wr;
            exp_rdata[m]      = '0;
        end else begin
            exp_slverr[m]     = 1'b0;
            exp_check_data[m] = !wr;
            exp_rdata[m]      = exp_mem[slave][word];
        end
        @(posedge aclk);
        m_psel[m]    <= 1'b1;
        m_penable[m] <= 1'b0;
        m_pwrite[m]  <= wr;
        m_pprot[m]   <= prot_width'(word + m);
        m_paddr[m]   <= addr;
        m_pwdata[m]  <= wdata;
        m_pstrb[m]   <= '1;
        @(posedge aclk);
        m_penable[m] <= 1'b1;
        do @(posedge aclk); while (!m_pready[m]);
        m_psel[m]    <= 1'b0;
        m_penable[m] <= 1'b0;
        if (wr && !exp_slverr[m]) exp_mem[slave][word] = wdata;
        transfer_count++;
    endtask

    task automatic write_read_all(input int m);
        logic [addr_width-1:0] addr;
        for (int k = 0; k < num_slaves; k++) begin
            // masters walk the slaves in opposite orders
            addr = make_addr((m == 0) ? k : num_slaves - 1 - k, 8 + m);
            apb_transfer(m, 1'b1, addr, $urandom);
            apb_transfer(m, 1'b0, addr, '0);
        end
    endtask

    task automatic run_burst(input int m, input int slave, input int n);
        logic                  wr;
        int                    word;
        logic [data_width-1:0] data;
        for (int i = 0; i < n; i++) begin
            wr   = 1'($urandom % 2);
            word = int'((($urandom % 16) << 1) | 32'(m));  // own words per master
            data = $urandom;
            apb_transfer(m, wr, make_addr(slave, word), data);
        end
    endtask

    task automatic finish_test(input string name);
        @(posedge aclk);
        test_count++;
        if (error_count == errors_at_start) begin
            $display("test %-12s ok, %0d transfers so far", name, transfer_count);
        end else begin
            $display("test %-12s %0d errors", name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    initial begin
        int sel_before;
        int overlap_before;
        void'($urandom(50));
        aresetn   = 1'b0;
        m_psel    = '0;
        m_penable = '0;
        m_pwrite  = '0;
        m_pprot   = '0;
        m_paddr   = '0;
        m_pwdata  = '0;
        m_pstrb   = '0;
        for (int s = 0; s < num_slaves; s++) begin
            for (int w = 0; w < 1024; w++) begin
                exp_mem[s][w] = fill_word(s, w);
            end
        end
        repeat (reset_cycles) @(posedge aclk);
        aresetn <= 1'b1;
        @(posedge aclk);
        finish_test("reset");

        fork
            write_read_all(0);
            write_read_all(1);
        join
        finish_test("write_read");

        sel_before = sel_cycles;
        apb_transfer(0, 1'b1, make_addr(num_slaves, 1), 32'h0bad_0001);
        apb_transfer(0, 1'b0, make_addr(num_slaves, 1), '0);
        apb_transfer(1, 1'b1, make_addr('h80000, 3), 32'h0bad_0002);
        apb_transfer(1, 1'b0, make_addr('hfffff, 7), '0);
        @(posedge aclk);
        assert (sel_cycles == sel_before) else begin
            $display("a slave was selected during a decode miss");
            error_count++;
        end
        finish_test("decode_miss");

        apb_transfer(0, 1'b1, make_addr(0, 517), 32'hdead_beef);  // offset bit 11 set
        apb_transfer(0, 1'b0, make_addr(0, 517), '0);
        apb_transfer(1, 1'b1, make_addr(3, 600), 32'h1234_5678);
        apb_transfer(1, 1'b0, make_addr(3, 600), '0);
        apb_transfer(0, 1'b0, make_addr(0, 517), '0);
        apb_transfer(1, 1'b0, make_addr(3, 600), '0);
        finish_test("slave_error");

        fork
            run_burst(0, 2, burst_len);
            run_burst(1, 2, burst_len);
        join
        finish_test("contention");

        overlap_before = overlap_cycles;
        fork
            run_burst(0, 1, burst_len / 2);
            run_burst(1, 3, burst_len / 2);
        join
        @(posedge aclk);
        assert (overlap_cycles > overlap_before) else begin
            $display("the two slaves were never selected together");
            error_count++;
        end
        finish_test("parallel");

        $display("tests %0d, transfers %0d, errors %0d",
                 test_count, transfer_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: common/apb_xbar_pkg.sv
`default_nettype none

package apb_xbar_pkg;

    //////////////////////////////////////////////////////////////////////
    // crossbar sizes

    localparam int num_masters = 2;
    localparam int num_slaves  = 4;
    localparam int mid_width   = 1;     // master index
    localparam int sid_width   = 2;     // slave index

    //////////////////////////////////////////////////////////////////////
    // apb field widths

    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;
    localparam int prot_width = 3;

    // region map: one 4 KB window per slave at the bottom of the space,
    // region numbers at or above num_slaves are decode misses
    localparam int offset_width = 12;
    localparam int region_width = addr_width - offset_width;

    //////////////////////////////////////////////////////////////////////
    // fsm encodings

    localparam int state_width = 2;

    // command capture
    localparam logic [state_width-1:0] cap_idle    = 2'd0;
    localparam logic [state_width-1:0] cap_pending = 2'd1;
    localparam logic [state_width-1:0] cap_respond = 2'd2;

    // target port
    localparam logic [state_width-1:0] tp_idle   = 2'd0;
    localparam logic [state_width-1:0] tp_setup  = 2'd1;
    localparam logic [state_width-1:0] tp_access = 2'd2;

    // address word, read raw or as region + offset
    typedef union packed {
        logic [addr_width-1:0] raw;
        struct packed {
            logic [region_width-1:0] region;
            logic [offset_width-1:0] offset;
        } map;
    } apb_addr_u;

endpackage

`default_nettype wire

// File: source/apb_cmd_capture.sv
`timescale 1ns/10ps
`default_nettype none

module apb_cmd_capture (
    input  logic                                aclk,
    input  logic                                aresetn,
    // apb completer side
    input  logic                                i_psel,
    input  logic                                i_penable,
    input  logic                                i_pwrite,
    input  logic [apb_xbar_pkg::prot_width-1:0] i_pprot,
    input  logic [apb_xbar_pkg::addr_width-1:0] i_paddr,
    input  logic [apb_xbar_pkg::data_width-1:0] i_pwdata,
    input  logic [apb_xbar_pkg::strb_width-1:0] i_pstrb,
    output logic                                o_pready,
    output logic [apb_xbar_pkg::data_width-1:0] o_prdata,
    output logic                                o_pslverr,
    // fabric side
    output logic [apb_xbar_pkg::num_slaves-1:0] o_req,
    output logic                                o_pwrite,
    output logic [apb_xbar_pkg::prot_width-1:0] o_pprot,
    output apb_xbar_pkg::apb_addr_u             o_addr,
    output logic [apb_xbar_pkg::data_width-1:0] o_wdata,
    output logic [apb_xbar_pkg::strb_width-1:0] o_strb,
    input  logic                                i_done,
    input  logic [apb_xbar_pkg::data_width-1:0] i_rdata,
    input  logic                                i_slverr
);

    import apb_xbar_pkg::*;

    logic [state_width-1:0] r_state;
    apb_addr_u              in_addr;
    logic                   access_seen;
    logic                   region_hit;
    logic [num_slaves-1:0]  hit_onehot;

    assign in_addr.raw = i_paddr;
    assign access_seen = i_psel && i_penable && (r_state == cap_idle);
    assign region_hit  = (in_addr.map.region < region_width'(num_slaves));
    assign hit_onehot  = num_slaves'(1) << in_addr.map.region[sid_width-1:0];

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_state <= cap_idle;
            o_req   <= '0;
        end else begin
            case (r_state)
                cap_idle: begin
                    if (access_seen && region_hit) begin
                        r_state <= cap_pending;
                        o_req   <= hit_onehot;
                    end else if (access_seen) begin
                        r_state <= cap_respond;     // miss answered locally
                    end
                end
                cap_pending: begin
                    if (i_done) begin
                        r_state <= cap_respond;
                        o_req   <= '0;
                    end
                end
                default: r_state <= cap_idle;       // respond lasts one cycle
            endcase
        end
    end

    // transfer fields and response
    always_ff @(posedge aclk) begin
        if (access_seen) begin
            o_pwrite <= i_pwrite;
            o_pprot  <= i_pprot;
            o_addr   <= in_addr;
            o_wdata  <= i_pwdata;
            o_strb   <= i_pstrb;
        end
        if (access_seen && !region_hit) begin
            o_prdata  <= '0;
            o_pslverr <= 1'b1;
        end else if ((r_state == cap_pending) && i_done) begin
            o_prdata  <= i_rdata;
            o_pslverr <= i_slverr;
        end
    end

    assign o_pready = (r_state == cap_respond);

    // one slave requested while pending, none in idle or while answering
    assert property (@(posedge aclk) disable iff (!aresetn)
        (r_state == cap_pending) ? $onehot(o_req) : (o_req == '0));

endmodule

`default_nettype wire

// File: source/apb_rr_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module apb_rr_arbiter (
    input  logic                                 aclk,
    input  logic                                 aresetn,
    input  logic [apb_xbar_pkg::num_masters-1:0] i_req,
    input  logic                                 i_done,
    output logic                                 o_gnt_valid,
    output logic [apb_xbar_pkg::mid_width-1:0]   o_gnt_id
);

    import apb_xbar_pkg::*;

    logic [mid_width-1:0] r_ptr;    // first master to look at
    logic                 pick_valid;
    logic [mid_width-1:0] pick_id;

    // scan from the far end so the nearest requester at or after r_ptr wins
    always_comb begin
        pick_valid = 1'b0;
        pick_id    = r_ptr;
        for (int k = num_masters - 1; k >= 0; k--) begin
            if (i_req[(int'(r_ptr) + k) % num_masters]) begin
                pick_valid = 1'b1;
                pick_id    = mid_width'((int'(r_ptr) + k) % num_masters);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // held grant

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            o_gnt_valid <= 1'b0;
            o_gnt_id    <= '0;
            r_ptr       <= '0;
        end else if (!o_gnt_valid) begin
            if (pick_valid) begin
                o_gnt_valid <= 1'b1;
                o_gnt_id    <= pick_id;
            end
        end else if (i_done) begin
            o_gnt_valid <= 1'b0;
            r_ptr       <= mid_width'((int'(o_gnt_id) + 1) % num_masters); // past winner
        end
    end

    // the target port only finishes a transfer that was granted
    assert property (@(posedge aclk) disable iff (!aresetn) i_done |-> o_gnt_valid);

endmodule

`default_nettype wire

// File: source/apb_target_port.sv
`timescale 1ns/10ps
`default_nettype none

module apb_target_port (
    input  logic                                aclk,
    input  logic                                aresetn,
    // granted command
    input  logic                                i_gnt_valid,
    input  logic                                i_pwrite,
    input  logic [apb_xbar_pkg::prot_width-1:0] i_pprot,
    input  apb_xbar_pkg::apb_addr_u             i_addr,
    input  logic [apb_xbar_pkg::data_width-1:0] i_wdata,
    input  logic [apb_xbar_pkg::strb_width-1:0] i_strb,
    // apb requester side
    output logic                                o_psel,
    output logic                                o_penable,
    output logic                                o_pwrite,
    output logic [apb_xbar_pkg::prot_width-1:0] o_pprot,
    output logic [apb_xbar_pkg::addr_width-1:0] o_paddr,
    output logic [apb_xbar_pkg::data_width-1:0] o_pwdata,
    output logic [apb_xbar_pkg::strb_width-1:0] o_pstrb,
    input  logic                                i_pready,
    input  logic [apb_xbar_pkg::data_width-1:0] i_prdata,
    input  logic                                i_pslverr,
    // completion
    output logic                                o_done,
    output logic [apb_xbar_pkg::data_width-1:0] o_rdata,
    output logic                                o_slverr
);

    import apb_xbar_pkg::*;

    logic [state_width-1:0] r_state;
    logic                   start;

    assign start = i_gnt_valid && (r_state == tp_idle);

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            r_state <= tp_idle;
        end else begin
            case (r_state)
                tp_idle: begin
                    if (start) begin
                        r_state <= tp_setup;
                    end
                end
                tp_setup:  r_state <= tp_access;
                tp_access: begin
                    if (i_pready) begin
                        r_state <= tp_idle;
                    end
                end
                default:   r_state <= tp_idle;
            endcase
        end
    end

    // fields latched once per transfer, held through setup and access
    always_ff @(posedge aclk) begin
        if (start) begin
            o_pwrite <= i_pwrite;
            o_pprot  <= i_pprot;
            o_paddr  <= i_addr.raw;
            o_pwdata <= i_wdata;
            o_pstrb  <= i_strb;
        end
    end

    assign o_psel    = (r_state == tp_setup) || (r_state == tp_access);
    assign o_penable = (r_state == tp_access);

    assign o_done   = o_penable && i_pready;  // same cycle pready is sampled
    assign o_rdata  = i_prdata;
    assign o_slverr = i_pslverr;

    // access only inside a selected transfer that still holds its grant
    assert property (@(posedge aclk) disable iff (!aresetn)
        o_penable |-> (o_psel && i_gnt_valid));

    assert property (@(posedge aclk) disable iff (!aresetn)
        o_penable |-> ($stable(o_paddr) && $stable(o_pwrite) && $stable(o_pwdata)
                       && $stable(o_pstrb) && $stable(o_pprot)));

endmodule

`default_nettype wire

// File: source/apb_xbar.sv
`timescale 1ns/10ps
`default_nettype none

module apb_xbar (
    input  logic                                                        aclk,
    input  logic                                                        aresetn,
    // master ports
    input  logic [apb_xbar_pkg::num_masters-1:0]                        i_m_psel,
    input  logic [apb_xbar_pkg::num_masters-1:0]                        i_m_penable,
    input  logic [apb_xbar_pkg::num_masters-1:0]                        i_m_pwrite,
    input  logic [apb_xbar_pkg::num_masters-1:0][apb_xbar_pkg::prot_width-1:0] i_m_pprot,
    input  logic [apb_xbar_pkg::num_masters-1:0][apb_xbar_pkg::addr_width-1:0] i_m_paddr,
    input  logic [apb_xbar_pkg::num_masters-1:0][apb_xbar_pkg::data_width-1:0] i_m_pwdata,
    input  logic [apb_xbar_pkg::num_masters-1:0][apb_xbar_pkg::strb_width-1:0] i_m_pstrb,
    output logic [apb_xbar_pkg::num_masters-1:0]                        o_m_pready,
    output logic [apb_xbar_pkg::num_masters-1:0][apb_xbar_pkg::data_width-1:0] o_m_prdata,
    output logic [apb_xbar_pkg::num_masters-1:0]                        o_m_pslverr,
    // slave ports
    output logic [apb_xbar_pkg::num_slaves-1:0]                         o_s_psel,
    output logic [apb_xbar_pkg::num_slaves-1:0]                         o_s_penable,
    output logic [apb_xbar_pkg::num_slaves-1:0]                         o_s_pwrite,
    output logic [apb_xbar_pkg::num_slaves-1:0][apb_xbar_pkg::prot_width-1:0]  o_s_pprot,
    output logic [apb_xbar_pkg::num_slaves-1:0][apb_xbar_pkg::addr_width-1:0]  o_s_paddr,
    output logic [apb_xbar_pkg::num_slaves-1:0][apb_xbar_pkg::data_width-1:0]  o_s_pwdata,
    output logic [apb_xbar_pkg::num_slaves-1:0][apb_xbar_pkg::strb_width-1:0]  o_s_pstrb,
    input  logic [apb_xbar_pkg::num_slaves-1:0]                         i_s_pready,
    input  logic [apb_xbar_pkg::num_slaves-1:0][apb_xbar_pkg::data_width-1:0]  i_s_prdata,
    input  logic [apb_xbar_pkg::num_slaves-1:0]                         i_s_pslverr
);

    import apb_xbar_pkg::*;

    // fabric side of each master
    logic      [num_masters-1:0][num_slaves-1:0] m_req;
    logic      [num_masters-1:0]                 m_pwrite;
    logic      [num_masters-1:0][prot_width-1:0] m_pprot;
    apb_addr_u [num_masters-1:0]                 m_addr;
    logic      [num_masters-1:0][data_width-1:0] m_wdata;
    logic      [num_masters-1:0][strb_width-1:0] m_strb;
    logic      [num_masters-1:0]                 m_done;
    logic      [num_masters-1:0][data_width-1:0] m_rdata;
    logic      [num_masters-1:0]                 m_slverr;

    // per slave: requests, grant, muxed command, completion
    logic      [num_slaves-1:0][num_masters-1:0] s_req;
    logic      [num_slaves-1:0]                  s_gnt_valid;
    logic      [num_slaves-1:0][mid_width-1:0]   s_gnt_id;
    logic      [num_slaves-1:0]                  s_pwrite;
    logic      [num_slaves-1:0][prot_width-1:0]  s_pprot;
    apb_addr_u [num_slaves-1:0]                  s_addr;
    logic      [num_slaves-1:0][data_width-1:0]  s_wdata;
    logic      [num_slaves-1:0][strb_width-1:0]  s_strb;
    logic      [num_slaves-1:0]                  s_done;
    logic      [num_slaves-1:0][data_width-1:0]  s_rdata;
    logic      [num_slaves-1:0]                  s_slverr;

    //////////////////////////////////////////////////////////////////////
    // master side

    for (genvar gm = 0; gm < num_masters; gm++) begin : gen_master
        apb_cmd_capture u_capture (
            .aclk      (aclk),
            .aresetn   (aresetn),
            .i_psel    (i_m_psel[gm]),
            .i_penable (i_m_penable[gm]),
            .i_pwrite  (i_m_pwrite[gm]),
            .i_pprot   (i_m_pprot[gm]),
            .i_paddr   (i_m_paddr[gm]),
            .i_pwdata  (i_m_pwdata[gm]),
            .i_pstrb   (i_m_pstrb[gm]),
            .o_pready  (o_m_pready[gm]),
            .o_prdata  (o_m_prdata[gm]),
            .o_pslverr (o_m_pslverr[gm]),
            .o_req     (m_req[gm]),
            .o_pwrite  (m_pwrite[gm]),
            .o_pprot   (m_pprot[gm]),
            .o_addr    (m_addr[gm]),
            .o_wdata   (m_wdata[gm]),
            .o_strb    (m_strb[gm]),
            .i_done    (m_done[gm]),
            .i_rdata   (m_rdata[gm]),
            .i_slverr  (m_slverr[gm])
        );

        // master-major to slave-major
        for (genvar gs = 0; gs < num_slaves; gs++) begin : gen_swap
            assign s_req[gs][gm] = m_req[gm][gs];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // slave side

    for (genvar gs = 0; gs < num_slaves; gs++) begin : gen_slave
        apb_rr_arbiter u_arbiter (
            .aclk        (aclk),
            .aresetn     (aresetn),
            .i_req       (s_req[gs]),
            .i_done      (s_done[gs]),
            .o_gnt_valid (s_gnt_valid[gs]),
            .o_gnt_id    (s_gnt_id[gs])
        );

        // command from the granted master
        assign s_pwrite[gs] = m_pwrite[s_gnt_id[gs]];
        assign s_pprot[gs]  = m_pprot[s_gnt_id[gs]];
        assign s_addr[gs]   = m_addr[s_gnt_id[gs]];
        assign s_wdata[gs]  = m_wdata[s_gnt_id[gs]];
        assign s_strb[gs]   = m_strb[s_gnt_id[gs]];

        apb_target_port u_target (
            .aclk        (aclk),
            .aresetn     (aresetn),
            .i_gnt_valid (s_gnt_valid[gs]),
            .i_pwrite    (s_pwrite[gs]),
            .i_pprot     (s_pprot[gs]),
            .i_addr      (s_addr[gs]),
            .i_wdata     (s_wdata[gs]),
            .i_strb      (s_strb[gs]),
            .o_psel      (o_s_psel[gs]),
            .o_penable   (o_s_penable[gs]),
            .o_pwrite    (o_s_pwrite[gs]),
            .o_pprot     (o_s_pprot[gs]),
            .o_paddr     (o_s_paddr[gs]),
            .o_pwdata    (o_s_pwdata[gs]),
            .o_pstrb     (o_s_pstrb[gs]),
            .i_pready    (i_s_pready[gs]),
            .i_prdata    (i_s_prdata[gs]),
            .i_pslverr   (i_s_pslverr[gs]),
            .o_done      (s_done[gs]),
            .o_rdata     (s_rdata[gs]),
            .o_slverr    (s_slverr[gs])
        );
    end

    // completion back to whichever master holds the grant;
    // a master has one transfer open, so at most one slave answers it
    always_comb begin
        m_done   = '0;
        m_rdata  = '0;
        m_slverr = '0;
        for (int s = 0; s < num_slaves; s++) begin
            if (s_gnt_valid[s] && s_done[s]) begin
                m_done[s_gnt_id[s]]   = 1'b1;
                m_rdata[s_gnt_id[s]]  = s_rdata[s];
                m_slverr[s_gnt_id[s]] = s_slverr[s];
            end
        end
    end

endmodule

`default_nettype wire
